// ==== common/div_config.svh ====
/*
  divider configuration
  operand width, iteration count and counter width
*/

`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// operand and result width in bits
`define DIV_WIDTH 32

// one quotient bit per iteration, so one step per operand bit
`define DIV_STEPS 32

// wide enough to hold the last step index
`define DIV_COUNT_W 5

`endif

// ==== common/div_pkg.sv ====
/*
  divider package
  request function and controller state encodings shared by the divider
*/

`default_nettype none

package div_pkg;

  // --------------------
  // request function
  // --------------------

  // selects plain unsigned division or signed division on magnitudes
  typedef enum logic {
    div_fn_unsigned = 1'b0,
    div_fn_signed   = 1'b1
  } div_fn_e;

  // --------------------
  // controller state
  // --------------------

  // idle waits for a request, calc runs the iterations, done holds the response
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } div_state_e;

endpackage

`default_nettype wire

// ==== int_div/int_div_ctrl.sv ====
/*
  divider controller
  idle, calc and done FSM that owns the request and response handshakes
*/

`timescale 1ns/1ps
`default_nettype none

module int_div_ctrl (
  input  wire  clk,
  input  wire  reset,
  input  wire  req_val,
  input  wire  resp_rdy,
  input  wire  count_done,
  output logic req_rdy,
  output logic resp_val,
  output logic load,
  output logic step
);

  div_pkg::div_state_e state;
  div_pkg::div_state_e state_next;

  // response leaves on this edge
  logic resp_xfer;

  // --------------------
  // output decode
  // --------------------

  // only idle takes a request
  assign req_rdy   = (state == div_pkg::st_idle);
  // response is held for as long as done lasts
  assign resp_val  = (state == div_pkg::st_done);
  // load equals the request transfer
  assign load      = req_rdy && req_val;
  // one iteration on every calc cycle
  assign step      = (state == div_pkg::st_calc);
  assign resp_xfer = resp_val && resp_rdy;

  // --------------------
  // next state
  // --------------------

  always_comb begin
    state_next = state;
    case (state)
      div_pkg::st_idle: begin
        if (load) begin
          state_next = div_pkg::st_calc;
        end
      end
      div_pkg::st_calc: begin
        // leave on the edge of the last iteration
        if (step && count_done) begin
          state_next = div_pkg::st_done;
        end
      end
      div_pkg::st_done: begin
        // back-pressure keeps us here with the results frozen
        if (resp_xfer) begin
          state_next = div_pkg::st_idle;
        end
      end
      default: begin
        state_next = div_pkg::st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= div_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

// ==== int_div/int_div_counter.sv ====
/*
  divider iteration counter
  counts calc steps and flags the last one
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_counter (
  input  wire  clk,
  input  wire  reset,
  input  wire  load,
  input  wire  step,
  output logic count_done
);

  logic [`DIV_COUNT_W-1:0] count;

  // high during the final step, index DIV_STEPS-1
  assign count_done = (count == `DIV_COUNT_W'(`DIV_STEPS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (load) begin
      // a new division starts from step zero
      count <= '0;
    end else if (step) begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== int_div/int_div_dpath.sv ====
/*
  divider magnitude datapath
  restoring shift-subtract on unsigned magnitudes, one quotient bit per step
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_dpath (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   load,
  input  wire                   step,
  input  wire [`DIV_WIDTH-1:0]  abs_a,
  input  wire [`DIV_WIDTH-1:0]  abs_b,
  output logic [`DIV_WIDTH-1:0] quot_mag,
  output logic [`DIV_WIDTH-1:0] rem_mag
);

  // --------------------
  // working registers
  // --------------------

  // upper part is the partial remainder, lower half fills with quotient bits
  logic [2*`DIV_WIDTH:0] work;
  // divisor sits over the remainder field, low half stays zero
  logic [2*`DIV_WIDTH:0] divisor;

  logic [2*`DIV_WIDTH:0] shifted;
  logic [2*`DIV_WIDTH:0] diff;
  logic                  diff_neg;
  logic [2*`DIV_WIDTH:0] work_next;

  // --------------------
  // one iteration
  // --------------------

  // bring the next dividend bit into the remainder field
  assign shifted  = work << 1;
  // trial subtraction, low half passes unchanged
  assign diff     = shifted - divisor;
  // top bit set means the divisor did not fit
  assign diff_neg = diff[2*`DIV_WIDTH];

  always_comb begin
    if (diff_neg) begin
      // restore, quotient bit 0
      work_next = {shifted[2*`DIV_WIDTH:1], 1'b0};
    end else begin
      // keep the difference, quotient bit 1
      work_next = {diff[2*`DIV_WIDTH:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      work <= '0;
    end else if (load) begin
      work <= {{(`DIV_WIDTH + 1){1'b0}}, abs_a};
    end else if (step) begin
      work <= work_next;
    end
  end

  // divisor only changes when a request is taken
  always_ff @(posedge clk) begin
    if (load) begin
      divisor <= {1'b0, abs_b, {`DIV_WIDTH{1'b0}}};
    end
  end

  // after the last step the remainder is below the divisor and fits in W bits
  assign quot_mag = work[`DIV_WIDTH-1:0];
  assign rem_mag  = work[2*`DIV_WIDTH-1:`DIV_WIDTH];

endmodule

`default_nettype wire

// ==== int_div/int_div_sign.sv ====
/*
  divider sign unit
  forms operand magnitudes and restores the result signs
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_sign (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   load,
  input  div_pkg::div_fn_e      req_fn,
  input  wire [`DIV_WIDTH-1:0]  req_a,
  input  wire [`DIV_WIDTH-1:0]  req_b,
  input  wire [`DIV_WIDTH-1:0]  quot_mag,
  input  wire [`DIV_WIDTH-1:0]  rem_mag,
  output logic [`DIV_WIDTH-1:0] abs_a,
  output logic [`DIV_WIDTH-1:0] abs_b,
  output logic [`DIV_WIDTH-1:0] resp_quotient,
  output logic [`DIV_WIDTH-1:0] resp_remainder
);

  logic is_signed;
  logic a_neg;
  logic b_neg;

  // sign flags captured with the request
  logic quot_neg;
  logic rem_neg;

  // --------------------
  // operand magnitudes
  // --------------------

  assign is_signed = (req_fn == div_pkg::div_fn_signed);
  // sign bits only count in the signed function
  assign a_neg     = is_signed && req_a[`DIV_WIDTH-1];
  assign b_neg     = is_signed && req_b[`DIV_WIDTH-1];

  // most negative value maps onto itself, which is the right unsigned magnitude
  assign abs_a = a_neg ? (~req_a + 1'b1) : req_a;
  assign abs_b = b_neg ? (~req_b + 1'b1) : req_b;

  always_ff @(posedge clk) begin
    if (reset) begin
      quot_neg <= 1'b0;
      rem_neg  <= 1'b0;
    end else if (load) begin
      // quotient negative when the signs differ
      quot_neg <= a_neg ^ b_neg;
      // remainder follows the dividend
      rem_neg  <= a_neg;
    end
  end

  // --------------------
  // result signs
  // --------------------

  assign resp_quotient  = quot_neg ? (~quot_mag + 1'b1) : quot_mag;
  assign resp_remainder = rem_neg ? (~rem_mag + 1'b1) : rem_mag;

endmodule

`default_nettype wire

// ==== rtl/int_div_top.sv ====
/*
  iterative integer divider
  valid/ready request and response ports around a restoring shift-subtract core
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_top (
  input  wire                   clk,
  input  wire                   reset,
  input  wire                   req_val,
  input  div_pkg::div_fn_e      req_fn,
  input  wire [`DIV_WIDTH-1:0]  req_a,
  input  wire [`DIV_WIDTH-1:0]  req_b,
  input  wire                   resp_rdy,
  output logic                  req_rdy,
  output logic                  resp_val,
  output logic [`DIV_WIDTH-1:0] resp_quotient,
  output logic [`DIV_WIDTH-1:0] resp_remainder
);

  // --------------------
  // internal strobes
  // --------------------

  logic                  load;
  logic                  step;
  logic                  count_done;

  // magnitudes between the sign unit and the datapath
  logic [`DIV_WIDTH-1:0] abs_a;
  logic [`DIV_WIDTH-1:0] abs_b;
  logic [`DIV_WIDTH-1:0] quot_mag;
  logic [`DIV_WIDTH-1:0] rem_mag;

  int_div_ctrl u_ctrl (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .resp_rdy   (resp_rdy),
    .count_done (count_done),
    .req_rdy    (req_rdy),
    .resp_val   (resp_val),
    .load       (load),
    .step       (step)
  );

  int_div_counter u_counter (
    .clk        (clk),
    .reset      (reset),
    .load       (load),
    .step       (step),
    .count_done (count_done)
  );

  int_div_sign u_sign (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .req_fn         (req_fn),
    .req_a          (req_a),
    .req_b          (req_b),
    .quot_mag       (quot_mag),
    .rem_mag        (rem_mag),
    .abs_a          (abs_a),
    .abs_b          (abs_b),
    .resp_quotient  (resp_quotient),
    .resp_remainder (resp_remainder)
  );

  int_div_dpath u_dpath (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .step     (step),
    .abs_a    (abs_a),
    .abs_b    (abs_b),
    .quot_mag (quot_mag),
    .rem_mag  (rem_mag)
  );

endmodule

`default_nettype wire

// ==== sim/int_div_sva.sv ====
/*
  divider handshake assertions
  bound into the controller, watches handshakes, stall behavior and latency
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_sva (
  input wire              clk,
  input wire              reset,
  input wire              resp_rdy,
  input wire              req_rdy,
  input wire              resp_val,
  input wire              load
);

  // --------------------
  // handshake
  // --------------------

  // reset leaves the block idle and ready
  a_reset_idle: assert property (@(posedge clk) reset |=> req_rdy && !resp_val)
    else $error("divider not idle after reset");

  a_no_overlap: assert property (@(posedge clk) disable iff (reset) !(req_rdy && resp_val))
    else $error("req_rdy and resp_val high together");

  // stalled response keeps valid
  a_hold_val: assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val)
    else $error("resp_val dropped before the response transfer");

  // --------------------
  // latency
  // --------------------

  // one cycle per quotient bit between the request edge and resp_val
  a_latency: assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> $past(load, `DIV_STEPS + 1))
    else $error("resp_val rose at the wrong distance from the request");

endmodule

`default_nettype wire

// ==== sim/int_div_tb.sv ====
/*
  divider testbench
  directed, corner, random and back-pressure requests checked against a reference model
*/

`timescale 1ns/1ps
`default_nettype none

`include "div_config.svh"

module int_div_tb;

  // about 230 transactions of up to 42 cycles, doubled
  localparam int TIMEOUT_CYCLES = 20000;

  logic                  clk;
  logic                  reset;
  logic                  req_val;
  div_pkg::div_fn_e      req_fn;
  logic [`DIV_WIDTH-1:0] req_a;
  logic [`DIV_WIDTH-1:0] req_b;
  logic                  resp_rdy;
  logic                  req_rdy;
  logic                  resp_val;
  logic [`DIV_WIDTH-1:0] resp_quotient;
  logic [`DIV_WIDTH-1:0] resp_remainder;

  // expected results, queued when a request is accepted
  logic [`DIV_WIDTH-1:0] exp_q[$];
  logic [`DIV_WIDTH-1:0] exp_r[$];
  int                    start_cycle[$];

  int                    cycle = 0;
  int                    acc_count = 0;
  int                    resp_count = 0;
  int                    check_count = 0;
  int                    err_count = 0;
  int                    lat_checks = 0;
  int                    lat_errs = 0;
  logic                  bp_mode;
  int unsigned           seed_ret;

  int_div_top u_dut (
    .clk            (clk),
    .reset          (reset),
    .req_val        (req_val),
    .req_fn         (req_fn),
    .req_a          (req_a),
    .req_b          (req_b),
    .resp_rdy       (resp_rdy),
    .req_rdy        (req_rdy),
    .resp_val       (resp_val),
    .resp_quotient  (resp_quotient),
    .resp_remainder (resp_remainder)
  );

  // handshake and latency assertions live inside the controller
  bind int_div_ctrl int_div_sva u_sva (
    .clk      (clk),
    .reset    (reset),
    .resp_rdy (resp_rdy),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .load     (load)
  );

  // --------------------
  // reference model
  // --------------------

  // divide the magnitudes, then negate per the sign rules
  function automatic logic [2*`DIV_WIDTH-1:0] ref_div(
    input div_pkg::div_fn_e      fn,
    input logic [`DIV_WIDTH-1:0] a,
    input logic [`DIV_WIDTH-1:0] b
  );
    logic                  a_neg;
    logic                  b_neg;
    logic [`DIV_WIDTH-1:0] ma;
    logic [`DIV_WIDTH-1:0] mb;
    logic [`DIV_WIDTH-1:0] q;
    logic [`DIV_WIDTH-1:0] r;
    a_neg = (fn == div_pkg::div_fn_signed) && a[`DIV_WIDTH-1];
    b_neg = (fn == div_pkg::div_fn_signed) && b[`DIV_WIDTH-1];
    ma = a_neg ? -a : a;
    mb = b_neg ? -b : b;
    if (mb == '0) begin
      // divide by zero gives all ones and the dividend magnitude
      q = '1;
      r = ma;
    end else begin
      q = ma / mb;
      r = ma % mb;
    end
    if (a_neg != b_neg) begin
      q = -q;
    end
    if (a_neg) begin
      r = -r;
    end
    return {q, r};
  endfunction

  function automatic div_pkg::div_fn_e random_fn();
    return ($urandom_range(0, 1) != 0) ? div_pkg::div_fn_signed : div_pkg::div_fn_unsigned;
  endfunction

  task automatic check_value(input string name, input logic [`DIV_WIDTH-1:0] expected,
                             input logic [`DIV_WIDTH-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      $display("** Error at %0t: %s expected %h got %h", $time, name, expected, actual);
      err_count++;
    end
  endtask

  // --------------------
  // clock, timeout
  // --------------------

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  initial begin
    while (cycle < TIMEOUT_CYCLES) @(posedge clk);
    $display("timeout after %0d cycles with %0d responses outstanding", cycle,
             acc_count - resp_count);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // --------------------
  // stimulus helpers
  // --------------------

  // called 1 ns after an edge, returns 1 ns after the transfer edge
  task automatic send_req(input div_pkg::div_fn_e fn, input logic [`DIV_WIDTH-1:0] a,
                          input logic [`DIV_WIDTH-1:0] b);
    req_val = 1'b1;
    req_fn  = fn;
    req_a   = a;
    req_b   = b;
    @(negedge clk);
    while (!req_rdy) @(negedge clk);
    @(posedge clk);
    #1;
    req_val = 1'b0;
  endtask

  task automatic drain();
    while (resp_count != acc_count) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name, input int err_before);
    $display("test %s done, %0d errors", name, err_count - err_before);
  endtask

  // random stretches of resp_rdy low while back-pressure is on
  initial begin
    int unsigned stretch;
    stretch  = 0;
    resp_rdy = 1'b1;
    forever begin
      @(posedge clk);
      #1;
      if (!bp_mode) begin
        resp_rdy = 1'b1;
      end else if (stretch == 0) begin
        resp_rdy = ($urandom_range(0, 2) == 0);
        stretch  = $urandom_range(1, 8);
      end else begin
        stretch = stretch - 1;
      end
    end
  end

  // --------------------
  // checker
  // --------------------

  // samples at the falling edge where everything has settled
  initial begin
    logic                  was_val;
    logic                  holding;
    logic [`DIV_WIDTH-1:0] held_q;
    logic [`DIV_WIDTH-1:0] held_r;
    logic [`DIV_WIDTH-1:0] eq;
    logic [`DIV_WIDTH-1:0] er;
    int                    lat;
    was_val = 1'b0;
    holding = 1'b0;
    held_q  = '0;
    held_r  = '0;
    forever begin
      @(negedge clk);
      if (!reset) begin
        // request transfers on the coming edge
        if (req_val && req_rdy) begin
          {eq, er} = ref_div(req_fn, req_a, req_b);
          exp_q.push_back(eq);
          exp_r.push_back(er);
          start_cycle.push_back(cycle + 1);
          acc_count++;
        end
        if (resp_val) begin
          if (!was_val) begin
            if (start_cycle.size() == 0) begin
              $display("response appeared at %0t with no accepted request", $time);
              err_count++;
            end else begin
              lat = cycle - start_cycle.pop_front();
              lat_checks++;
              if (lat != `DIV_STEPS) begin
                $display("** Error at %0t: resp_val latency expected %0d got %0d", $time,
                         `DIV_STEPS, lat);
                err_count++;
                lat_errs++;
              end
            end
          end
          // results must not move while the response waits
          if (holding) begin
            check_value("resp_quotient (held)", held_q, resp_quotient);
            check_value("resp_remainder (held)", held_r, resp_remainder);
          end
          if (resp_rdy) begin
            if (exp_q.size() == 0) begin
              $display("response taken at %0t with no expected result queued", $time);
              err_count++;
            end else begin
              check_value("resp_quotient", exp_q.pop_front(), resp_quotient);
              check_value("resp_remainder", exp_r.pop_front(), resp_remainder);
            end
            resp_count++;
            holding = 1'b0;
          end else begin
            holding = 1'b1;
            held_q  = resp_quotient;
            held_r  = resp_remainder;
          end
        end
        was_val = resp_val;
      end
    end
  end

  // --------------------
  // test sequence
  // --------------------

  initial begin
    int                    err_before;
    int                    n;
    int                    gap;
    logic [`DIV_WIDTH-1:0] ra;
    logic [`DIV_WIDTH-1:0] rb;
    seed_ret = $urandom(32'h91dc98be);
    reset    = 1'b1;
    req_val  = 1'b0;
    req_fn   = div_pkg::div_fn_unsigned;
    req_a    = '0;
    req_b    = '0;
    bp_mode  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    err_before = err_count;
    send_req(div_pkg::div_fn_unsigned, 32'd100, 32'd7);
    send_req(div_pkg::div_fn_unsigned, 32'd7, 32'd100);
    send_req(div_pkg::div_fn_unsigned, 32'd0, 32'd5);
    send_req(div_pkg::div_fn_unsigned, 32'h1234_5678, 32'd10);
    send_req(div_pkg::div_fn_unsigned, 32'hffff_ffff, 32'hffff_ffff);
    send_req(div_pkg::div_fn_unsigned, 32'hffff_ffff, 32'd1);
    drain();
    report_test("1 unsigned directed", err_before);

    err_before = err_count;
    send_req(div_pkg::div_fn_signed, 32'd100, 32'd7);
    send_req(div_pkg::div_fn_signed, -32'sd100, 32'd7);
    send_req(div_pkg::div_fn_signed, 32'd100, -32'sd7);
    send_req(div_pkg::div_fn_signed, -32'sd100, -32'sd7);
    // negative dividend, exact division
    send_req(div_pkg::div_fn_signed, -32'sd21, 32'd7);
    send_req(div_pkg::div_fn_signed, -32'sd7, 32'd100);
    drain();
    report_test("2 signed directed", err_before);

    err_before = err_count;
    send_req(div_pkg::div_fn_unsigned, 32'd1234, 32'd0);
    send_req(div_pkg::div_fn_signed, -32'sd1234, 32'd0);
    send_req(div_pkg::div_fn_signed, 32'd5, 32'd0);
    send_req(div_pkg::div_fn_signed, 32'h8000_0000, 32'hffff_ffff);
    send_req(div_pkg::div_fn_unsigned, 32'h8000_0000, 32'hffff_ffff);
    drain();
    report_test("3 corner cases", err_before);

    err_before = err_count;
    for (n = 0; n < 200; n++) begin
      ra = $urandom;
      rb = $urandom >> $urandom_range(0, 31);
      send_req(random_fn(), ra, rb);
      gap = $urandom_range(0, 3);
      // a nonzero gap lets the divider sit idle with req_val low
      if (gap != 0) begin
        drain();
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
    end
    drain();
    report_test("4 random mixed", err_before);

    // requests back to back, so req_val stays up while busy
    err_before = err_count;
    bp_mode    = 1'b1;
    for (n = 0; n < 25; n++) begin
      ra = $urandom;
      rb = $urandom >> $urandom_range(0, 31);
      send_req(random_fn(), ra, rb);
    end
    drain();
    bp_mode = 1'b0;
    // a stray transfer would surface as one more response within a division time
    repeat (`DIV_STEPS + 2) begin
      @(posedge clk);
      #1;
    end
    if (resp_count != acc_count || exp_q.size() != 0) begin
      $display("%0d responses for %0d accepted requests", resp_count, acc_count);
      err_count++;
    end
    report_test("5 back-pressure", err_before);

    $display("test 6 latency done, %0d checks, %0d errors", lat_checks, lat_errs);
    $display("checks %0d, errors %0d, requests %0d, responses %0d", check_count, err_count,
             acc_count, resp_count);
    if (err_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+common
common/div_pkg.sv
int_div/int_div_ctrl.sv
int_div/int_div_counter.sv
int_div/int_div_dpath.sv
int_div/int_div_sign.sv
rtl/int_div_top.sv
sim/int_div_sva.sv
sim/int_div_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the divider testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f verilog.f --top-module int_div_tb -o int_div_sim \
  && ./obj_dir/int_div_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null

grep -q "Simulation finished: FAIL" sim.log && { echo "run failed"; exit 1; }
grep -q "Simulation finished: PASS" sim.log || { echo "run did not complete"; exit 1; }
echo "run passed"
exit 0
